// ==== sim.f ====
hdl/lsu_l1d_pkg.sv
hdl/l1d_rd_arbiter.sv
hdl/l1d_array.sv
hdl/l1d_ptw_access.sv
hdl/l1d_snoop_access.sv
hdl/lsu_l1d_top.sv
tests/tb_lsu_l1d_top.sv

// ==== Bender.yml ====
package:
  name: lsu_l1d

sources:
  - hdl/lsu_l1d_pkg.sv
  - hdl/l1d_rd_arbiter.sv
  - hdl/l1d_array.sv
  - hdl/l1d_ptw_access.sv
  - hdl/l1d_snoop_access.sv
  - hdl/lsu_l1d_top.sv
  - target: test
    files:
      - tests/tb_lsu_l1d_top.sv

// ==== tests/tb_lsu_l1d_top.sv ====
`timescale 1ns/1ps

module tb_lsu_l1d_top;

  import lsu_l1d_pkg::*;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 8;
  // Cycle budget per test from reset to snoop
  localparam int TEST_CYCLES  = 12 + 16 + 16 + 20 + 24;
  localparam int TIMEOUT_NS   = (RESET_CYCLES + TEST_CYCLES + 100) * CLK_PERIOD;
  localparam int OFS_W        = $clog2(DCACHE_DATA_B_W);
  localparam int IDX_W        = $clog2(16);
  localparam int TAG_W        = PADDR_W - IDX_W - OFS_W;
  localparam logic [PADDR_W-1:0] ADDR_A = 32'h0000_4a50;
  localparam logic [PADDR_W-1:0] ADDR_B = 32'h0008_1030;

  logic         i_clk;
  logic         i_reset_n;
  snoop_req_t   snoop_req;
  snoop_resp_t  snoop_resp;
  ptw_req_t     ptw_req;
  ptw_resp_t    ptw_resp;
  l1d_rd_req_t  ls_req  [2];
  l1d_rd_resp_t ls_resp [2];
  l1d_wr_req_t  refill;
  logic         refill_ready;

  // Reference model of the cache contents
  logic [15:0]              ref_valid;
  logic [TAG_W-1:0]         ref_tag  [16];
  logic [DCACHE_DATA_W-1:0] ref_data [16];

  logic [31:0] lfsr_state;
  int          errors;
  int          checks;

  lsu_l1d_top UUT (
    .i_clk          (i_clk       ),
    .i_reset_n      (i_reset_n   ),
    .i_snoop_req    (snoop_req   ),
    .o_snoop_resp   (snoop_resp  ),
    .i_ptw_req      (ptw_req     ),
    .o_ptw_resp     (ptw_resp    ),
    .i_ls_req       (ls_req      ),
    .o_ls_resp      (ls_resp     ),
    .i_refill       (refill      ),
    .o_refill_ready (refill_ready)
  );

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  function automatic logic [DCACHE_DATA_W-1:0] take_line();
    logic [DCACHE_DATA_W-1:0] line;
    for (int i = 0; i < DCACHE_DATA_W; i++) begin
      line[i]    = lfsr_state[0];
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
    end
    return line;
  endfunction

  function automatic l1d_status_t model_status(logic [PADDR_W-1:0] paddr);
    logic [IDX_W-1:0] idx;
    idx = paddr[OFS_W +: IDX_W];
    if (ref_valid[idx] && ref_tag[idx] == paddr[PADDR_W-1 -: TAG_W]) begin
      return STATUS_HIT;
    end
    return STATUS_MISS;
  endfunction

  task automatic expect_eq(input string test, input string what,
                           input logic [DCACHE_DATA_W-1:0] exp,
                           input logic [DCACHE_DATA_W-1:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %s %s: expected %h, actual %h", test, what, exp, act);
    end
  endtask

  task automatic refill_line(input logic [PADDR_W-1:0] paddr,
                             input logic [DCACHE_DATA_W-1:0] line);
    logic [IDX_W-1:0] idx;
    idx = paddr[OFS_W +: IDX_W];
    @(posedge i_clk);
    refill.valid      <= 1'b1;
    refill.invalidate <= 1'b0;
    refill.paddr      <= paddr;
    refill.data       <= line;
    @(posedge i_clk);
    refill.valid      <= 1'b0;
    ref_valid[idx] = 1'b1;
    ref_tag[idx]   = paddr[PADDR_W-1 -: TAG_W];
    ref_data[idx]  = line;
  endtask

  task automatic ls_read(input int port, input logic [PADDR_W-1:0] paddr, input string test);
    l1d_status_t exp;
    exp = model_status(paddr);
    @(posedge i_clk);
    ls_req[port].valid <= 1'b1;
    ls_req[port].paddr <= paddr;
    @(posedge i_clk);
    ls_req[port].valid <= 1'b0;
    @(negedge i_clk);
    expect_eq(test, "ls valid", 1'b1, ls_resp[port].valid);
    expect_eq(test, "ls status", exp, ls_resp[port].status);
    if (exp == STATUS_HIT) begin
      expect_eq(test, "ls data", ref_data[paddr[OFS_W +: IDX_W]], ls_resp[port].data);
    end
  endtask

  task automatic ptw_read(input logic [PADDR_W-1:0] paddr, input string test);
    logic [DCACHE_DATA_W-1:0] line;
    line = ref_data[paddr[OFS_W +: IDX_W]];
    @(posedge i_clk);
    ptw_req.valid <= 1'b1;
    ptw_req.paddr <= paddr;
    @(posedge i_clk);
    ptw_req.valid <= 1'b0;
    @(negedge i_clk);
    expect_eq(test, "ptw valid", 1'b1, ptw_resp.valid);
    expect_eq(test, "ptw status", model_status(paddr), ptw_resp.status);
    expect_eq(test, "ptw data", paddr[3] ? line[127:64] : line[63:0], ptw_resp.data);
  endtask

  task automatic snoop_read(input logic [PADDR_W-1:0] paddr, input string test);
    l1d_status_t exp;
    exp = model_status(paddr);
    @(posedge i_clk);
    snoop_req.valid <= 1'b1;
    snoop_req.cmd   <= SNOOP_READ;
    snoop_req.paddr <= paddr;
    @(posedge i_clk);
    snoop_req.valid <= 1'b0;
    @(negedge i_clk);
    expect_eq(test, "snoop valid", 1'b1, snoop_resp.valid);
    expect_eq(test, "snoop status", exp, snoop_resp.status);
    expect_eq(test, "snoop be", (exp == STATUS_HIT) ? 16'hffff : 16'h0, snoop_resp.be);
    if (exp == STATUS_HIT) begin
      expect_eq(test, "snoop data", ref_data[paddr[OFS_W +: IDX_W]], snoop_resp.data);
    end
  endtask

  // Mask bits are snoop, PTW, LS0, LS1 from bit 0 up
  task automatic priority_round(input logic [3:0] mask);
    logic [PADDR_W-1:0] paddr_of [4];
    logic [3:0]         act_v;
    l1d_status_t        act_s [4];
    int                 winner;
    string              test;
    paddr_of[0] = ADDR_A;
    paddr_of[1] = ADDR_B | 32'h8;
    paddr_of[2] = ADDR_A;
    paddr_of[3] = ADDR_B;
    test   = $sformatf("priority_%b", mask);
    winner = -1;
    for (int p = 3; p >= 0; p--) begin
      if (mask[p]) winner = p;
    end
    @(posedge i_clk);
    snoop_req.valid  <= mask[0];
    snoop_req.cmd    <= SNOOP_READ;
    snoop_req.paddr  <= paddr_of[0];
    ptw_req.valid    <= mask[1];
    ptw_req.paddr    <= paddr_of[1];
    ls_req[0].valid  <= mask[2];
    ls_req[0].paddr  <= paddr_of[2];
    ls_req[1].valid  <= mask[3];
    ls_req[1].paddr  <= paddr_of[3];
    @(posedge i_clk);
    snoop_req.valid  <= 1'b0;
    ptw_req.valid    <= 1'b0;
    ls_req[0].valid  <= 1'b0;
    ls_req[1].valid  <= 1'b0;
    @(negedge i_clk);
    act_v    = {ls_resp[1].valid, ls_resp[0].valid, ptw_resp.valid, snoop_resp.valid};
    act_s[0] = snoop_resp.status;
    act_s[1] = ptw_resp.status;
    act_s[2] = ls_resp[0].status;
    act_s[3] = ls_resp[1].status;
    for (int p = 0; p < 4; p++) begin
      expect_eq(test, $sformatf("port %0d valid", p), mask[p], act_v[p]);
      if (mask[p]) begin
        expect_eq(test, $sformatf("port %0d status", p),
                  (p == winner) ? model_status(paddr_of[p]) : STATUS_L1D_CONFLICT, act_s[p]);
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------
  task automatic test_reset();
    logic [DCACHE_DATA_W-1:0] bits;
    @(negedge i_clk);
    expect_eq("reset", "valids", 4'b0,
              {snoop_resp.valid, ptw_resp.valid, ls_resp[0].valid, ls_resp[1].valid});
    expect_eq("reset", "refill ready", 1'b1, refill_ready);
    bits = take_line();
    ls_read(0, bits[31:0], "reset");
    ls_read(1, ADDR_A, "reset");
  endtask

  task automatic test_refill_read();
    logic [DCACHE_DATA_W-1:0] line;
    line = take_line();
    refill_line(ADDR_A, line);
    ls_read(0, ADDR_A, "refill_read");
    ls_read(1, ADDR_A, "refill_read");
    // Same index with another tag
    ls_read(1, 32'h0000_7b50, "refill_read");
  endtask

  task automatic test_ptw();
    logic [DCACHE_DATA_W-1:0] line;
    line = take_line();
    refill_line(ADDR_B, line);
    ptw_read(ADDR_B, "ptw");
    ptw_read(ADDR_B | 32'h8, "ptw");
  endtask

  task automatic test_priority();
    priority_round(4'b1111);
    priority_round(4'b1110);
    priority_round(4'b1100);
    priority_round(4'b1000);
  endtask

  task automatic test_snoop();
    logic [DCACHE_DATA_W-1:0] line;
    snoop_read(ADDR_A, "snoop");
    line = take_line();
    // Invalidate with a competing refill to the same line
    @(posedge i_clk);
    snoop_req.valid   <= 1'b1;
    snoop_req.cmd     <= SNOOP_INVALID;
    snoop_req.paddr   <= ADDR_A;
    refill.valid      <= 1'b1;
    refill.invalidate <= 1'b0;
    refill.paddr      <= ADDR_A;
    refill.data       <= line;
    @(negedge i_clk);
    expect_eq("snoop", "refill ready", 1'b0, refill_ready);
    @(posedge i_clk);
    snoop_req.valid <= 1'b0;
    refill.valid    <= 1'b0;
    ref_valid[ADDR_A[OFS_W +: IDX_W]] = 1'b0;
    @(negedge i_clk);
    expect_eq("snoop", "inv valid", 1'b1, snoop_resp.valid);
    expect_eq("snoop", "inv status", STATUS_NONE, snoop_resp.status);
    expect_eq("snoop", "refill ready", 1'b1, refill_ready);
    snoop_read(ADDR_A, "snoop");
    ls_read(0, ADDR_A, "snoop");
  endtask

  // ----------------------------------------------------------------------
  // Run control
  // ----------------------------------------------------------------------
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: tests did not finish within %0d ns", TIMEOUT_NS);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    i_clk      = 1'b0;
    i_reset_n  = 1'b0;
    snoop_req  = '0;
    ptw_req    = '0;
    ls_req[0]  = '0;
    ls_req[1]  = '0;
    refill     = '0;
    ref_valid  = '0;
    lfsr_state = 32'he166_1ba1;
    errors     = 0;
    checks     = 0;
    repeat (RESET_CYCLES) @(posedge i_clk);
    i_reset_n <= 1'b1;
    test_reset();
    test_refill_read();
    test_ptw();
    test_priority();
    test_snoop();
    repeat (2) @(posedge i_clk);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== hdl/lsu_l1d_top.sv ====
`timescale 1ns/1ps

module lsu_l1d_top #(
  parameter int LS_PORT_NUM = 2,
  parameter int DCACHE_SETS = 16
) (
  input  logic                      i_clk,
  input  logic                      i_reset_n,

  input  lsu_l1d_pkg::snoop_req_t   i_snoop_req,
  output lsu_l1d_pkg::snoop_resp_t  o_snoop_resp,

  input  lsu_l1d_pkg::ptw_req_t     i_ptw_req,
  output lsu_l1d_pkg::ptw_resp_t    o_ptw_resp,

  input  lsu_l1d_pkg::l1d_rd_req_t  i_ls_req  [LS_PORT_NUM],
  output lsu_l1d_pkg::l1d_rd_resp_t o_ls_resp [LS_PORT_NUM],

  // Line fills from the miss side
  input  lsu_l1d_pkg::l1d_wr_req_t  i_refill,
  output logic                      o_refill_ready
);

  import lsu_l1d_pkg::*;

  // Port order sets priority, lowest index first
  localparam int SNOOP_PORT   = 0;
  localparam int PTW_PORT     = 1;
  localparam int LS_PORT_BASE = 2;
  localparam int RD_PORT_NUM  = LS_PORT_NUM + 2;

  l1d_rd_req_t              w_rd_req  [RD_PORT_NUM];
  l1d_rd_resp_t             w_rd_resp [RD_PORT_NUM];

  logic                     w_array_rd_valid;
  logic [PADDR_W-1:0]       w_array_rd_paddr;
  logic                     w_array_s1_hit;
  logic [DCACHE_DATA_W-1:0] w_array_s1_data;

  l1d_wr_req_t              w_inv_req;
  l1d_wr_req_t              w_wr_req;

  // ----------------------------------------------------------------------
  // Read clients
  // ----------------------------------------------------------------------
  l1d_snoop_access u_snoop_access (
    .i_clk        (i_clk                ),
    .i_reset_n    (i_reset_n            ),
    .i_snoop_req  (i_snoop_req          ),
    .o_snoop_resp (o_snoop_resp         ),
    .o_rd_req     (w_rd_req [SNOOP_PORT]),
    .i_rd_resp    (w_rd_resp[SNOOP_PORT]),
    .o_inv_req    (w_inv_req            )
  );

  l1d_ptw_access u_ptw_access (
    .i_clk      (i_clk              ),
    .i_reset_n  (i_reset_n          ),
    .i_ptw_req  (i_ptw_req          ),
    .o_ptw_resp (o_ptw_resp         ),
    .o_rd_req   (w_rd_req [PTW_PORT]),
    .i_rd_resp  (w_rd_resp[PTW_PORT])
  );

  for (genvar i = 0; i < LS_PORT_NUM; i++) begin : g_ls_port
    assign w_rd_req[LS_PORT_BASE + i] = i_ls_req[i];
    assign o_ls_resp[i]               = w_rd_resp[LS_PORT_BASE + i];
  end

  // ----------------------------------------------------------------------
  // Arbiter and array
  // ----------------------------------------------------------------------
  l1d_rd_arbiter #(
    .RD_PORT_NUM (RD_PORT_NUM)
  ) u_rd_arbiter (
    .i_clk            (i_clk           ),
    .i_reset_n        (i_reset_n       ),
    .i_rd_req         (w_rd_req        ),
    .o_rd_resp        (w_rd_resp       ),
    .o_array_rd_valid (w_array_rd_valid),
    .o_array_rd_paddr (w_array_rd_paddr),
    .i_array_s1_hit   (w_array_s1_hit  ),
    .i_array_s1_data  (w_array_s1_data )
  );

  // Invalidate owns the write path, refill waits
  assign o_refill_ready = !w_inv_req.valid;
  assign w_wr_req       = w_inv_req.valid ? w_inv_req : i_refill;

  l1d_array #(
    .DCACHE_SETS (DCACHE_SETS)
  ) u_array (
    .i_clk      (i_clk           ),
    .i_reset_n  (i_reset_n       ),
    .i_rd_valid (w_array_rd_valid),
    .i_rd_paddr (w_array_rd_paddr),
    .o_s1_hit   (w_array_s1_hit  ),
    .o_s1_data  (w_array_s1_data ),
    .i_wr_req   (w_wr_req        )
  );

endmodule

// ==== hdl/l1d_snoop_access.sv ====
`timescale 1ns/1ps

module l1d_snoop_access (
  input  logic                      i_clk,
  input  logic                      i_reset_n,

  input  lsu_l1d_pkg::snoop_req_t   i_snoop_req,
  output lsu_l1d_pkg::snoop_resp_t  o_snoop_resp,

  // Read port with the highest priority
  output lsu_l1d_pkg::l1d_rd_req_t  o_rd_req,
  input  lsu_l1d_pkg::l1d_rd_resp_t i_rd_resp,

  // Invalidate onto the array write path
  output lsu_l1d_pkg::l1d_wr_req_t  o_inv_req
);

  import lsu_l1d_pkg::*;

  logic r_resp_valid;
  logic w_s1_hit;

  // ----------------------------------------------------------------------
  // Command decode
  // ----------------------------------------------------------------------
  assign o_rd_req.valid = i_snoop_req.valid & (i_snoop_req.cmd == SNOOP_READ);
  assign o_rd_req.paddr = i_snoop_req.paddr;

  assign o_inv_req.valid      = i_snoop_req.valid & (i_snoop_req.cmd == SNOOP_INVALID);
  assign o_inv_req.invalidate = 1'b1;
  assign o_inv_req.paddr      = i_snoop_req.paddr;
  assign o_inv_req.data       = '0;

  // Reads and invalidates are both answered
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_resp_valid <= 1'b0;
    end else begin
      r_resp_valid <= i_snoop_req.valid;
    end
  end

  // ----------------------------------------------------------------------
  // s1 response
  // ----------------------------------------------------------------------
  assign w_s1_hit = (i_rd_resp.status == STATUS_HIT);

  assign o_snoop_resp.valid  = r_resp_valid;
  // The read port reports NONE when no read stands behind an invalidate
  assign o_snoop_resp.status = i_rd_resp.status;
  assign o_snoop_resp.be     = {DCACHE_DATA_B_W{w_s1_hit}};
  assign o_snoop_resp.data   = i_rd_resp.data;

  a_cmd_known : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_snoop_req.valid |-> !$isunknown(i_snoop_req.cmd)
  );

endmodule

// ==== hdl/l1d_ptw_access.sv ====
`timescale 1ns/1ps

module l1d_ptw_access (
  input  logic                      i_clk,
  input  logic                      i_reset_n,

  input  lsu_l1d_pkg::ptw_req_t     i_ptw_req,
  output lsu_l1d_pkg::ptw_resp_t    o_ptw_resp,

  // Dedicated read port on the arbiter
  output lsu_l1d_pkg::l1d_rd_req_t  o_rd_req,
  input  lsu_l1d_pkg::l1d_rd_resp_t i_rd_resp
);

  import lsu_l1d_pkg::*;

  localparam int WORD_NUM = DCACHE_DATA_W / XLEN_W;
  localparam int SEL_W    = $clog2(WORD_NUM);
  // Lowest paddr bit above the byte offset within a word
  localparam int SEL_LSB  = $clog2(XLEN_W / 8);

  logic [SEL_W-1:0] r_word_sel;

  // ----------------------------------------------------------------------
  // s0 request
  // ----------------------------------------------------------------------
  assign o_rd_req.valid = i_ptw_req.valid;
  assign o_rd_req.paddr = i_ptw_req.paddr;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_word_sel <= '0;
    end else if (i_ptw_req.valid) begin
      r_word_sel <= i_ptw_req.paddr[SEL_LSB +: SEL_W];
    end
  end

  // ----------------------------------------------------------------------
  // s1 response
  // ----------------------------------------------------------------------
  assign o_ptw_resp.valid  = i_rd_resp.valid;
  assign o_ptw_resp.status = i_rd_resp.status;
  assign o_ptw_resp.data   = i_rd_resp.data[r_word_sel * XLEN_W +: XLEN_W];

endmodule

// ==== hdl/l1d_array.sv ====
`timescale 1ns/1ps

module l1d_array #(
  parameter int DCACHE_SETS = 16
) (
  input  logic                                  i_clk,
  input  logic                                  i_reset_n,

  // Read path, answered one cycle later
  input  logic                                  i_rd_valid,
  input  logic [lsu_l1d_pkg::PADDR_W-1:0]       i_rd_paddr,
  output logic                                  o_s1_hit,
  output logic [lsu_l1d_pkg::DCACHE_DATA_W-1:0] o_s1_data,

  // Write path, fill or invalidate
  input  lsu_l1d_pkg::l1d_wr_req_t              i_wr_req
);

  import lsu_l1d_pkg::*;

  localparam int OFS_W = $clog2(DCACHE_DATA_B_W);
  localparam int IDX_W = $clog2(DCACHE_SETS);
  localparam int TAG_W = PADDR_W - IDX_W - OFS_W;

  logic [TAG_W-1:0]         r_tag  [DCACHE_SETS];
  logic [DCACHE_DATA_W-1:0] r_data [DCACHE_SETS];
  logic [DCACHE_SETS-1:0]   r_valid;

  logic [IDX_W-1:0]         w_rd_idx;
  logic [TAG_W-1:0]         w_rd_tag;
  logic                     w_rd_hit;
  logic [IDX_W-1:0]         w_wr_idx;
  logic [TAG_W-1:0]         w_wr_tag;

  logic                     r_s1_hit;
  logic [DCACHE_DATA_W-1:0] r_s1_data;

  // Address split into tag, index and byte offset
  assign w_rd_idx = i_rd_paddr[OFS_W +: IDX_W];
  assign w_rd_tag = i_rd_paddr[OFS_W + IDX_W +: TAG_W];
  assign w_wr_idx = i_wr_req.paddr[OFS_W +: IDX_W];
  assign w_wr_tag = i_wr_req.paddr[OFS_W + IDX_W +: TAG_W];

  assign w_rd_hit = r_valid[w_rd_idx] & (r_tag[w_rd_idx] == w_rd_tag);

  // ----------------------------------------------------------------------
  // Storage update
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
    end else if (i_wr_req.valid) begin
      r_valid[w_wr_idx] <= !i_wr_req.invalidate;
    end
  end

  // Invalidate leaves tag and data as they were
  always_ff @(posedge i_clk) begin
    if (i_wr_req.valid && !i_wr_req.invalidate) begin
      r_tag[w_wr_idx]  <= w_wr_tag;
      r_data[w_wr_idx] <= i_wr_req.data;
    end
  end

  // ----------------------------------------------------------------------
  // Registered read
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_hit <= 1'b0;
    end else begin
      r_s1_hit <= i_rd_valid & w_rd_hit;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rd_valid) begin
      r_s1_data <= r_data[w_rd_idx];
    end
  end

  assign o_s1_hit  = r_s1_hit;
  assign o_s1_data = r_s1_data;

  // Covers both writers muxed in the top, snoop and refill
  a_wr_paddr_known : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_wr_req.valid |-> !$isunknown(i_wr_req.paddr)
  );

endmodule

// ==== hdl/l1d_rd_arbiter.sv ====
`timescale 1ns/1ps

module l1d_rd_arbiter #(
  parameter int RD_PORT_NUM = 4
) (
  input  logic                                  i_clk,
  input  logic                                  i_reset_n,

  input  lsu_l1d_pkg::l1d_rd_req_t              i_rd_req  [RD_PORT_NUM],
  output lsu_l1d_pkg::l1d_rd_resp_t             o_rd_resp [RD_PORT_NUM],

  // Single read path into the array
  output logic                                  o_array_rd_valid,
  output logic [lsu_l1d_pkg::PADDR_W-1:0]       o_array_rd_paddr,
  input  logic                                  i_array_s1_hit,
  input  logic [lsu_l1d_pkg::DCACHE_DATA_W-1:0] i_array_s1_data
);

  import lsu_l1d_pkg::*;

  logic [RD_PORT_NUM-1:0] w_req_valid;
  logic [RD_PORT_NUM-1:0] w_grant;
  logic [RD_PORT_NUM-1:0] r_grant;
  logic [RD_PORT_NUM-1:0] r_req_mask;

  // ----------------------------------------------------------------------
  // s0 grant
  // ----------------------------------------------------------------------
  always_comb begin
    for (int p = 0; p < RD_PORT_NUM; p++) begin
      w_req_valid[p] = i_rd_req[p].valid;
    end
  end

  // Lowest set bit wins so port 0 has top priority
  assign w_grant = w_req_valid & (~w_req_valid + RD_PORT_NUM'(1));

  assign o_array_rd_valid = |w_req_valid;

  always_comb begin
    o_array_rd_paddr = '0;
    for (int p = 0; p < RD_PORT_NUM; p++) begin
      o_array_rd_paddr |= i_rd_req[p].paddr & {PADDR_W{w_grant[p]}};
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_grant    <= '0;
      r_req_mask <= '0;
    end else begin
      r_grant    <= w_grant;
      r_req_mask <= w_req_valid;
    end
  end

  // ----------------------------------------------------------------------
  // s1 response per port
  // ----------------------------------------------------------------------
  for (genvar p = 0; p < RD_PORT_NUM; p++) begin : g_resp
    assign o_rd_resp[p].valid  = r_req_mask[p];
    assign o_rd_resp[p].status = r_grant[p]    ? (i_array_s1_hit ? STATUS_HIT : STATUS_MISS) :
                                 r_req_mask[p] ? STATUS_L1D_CONFLICT :
                                                 STATUS_NONE;
    // Losers see the winner's line and go by their status
    assign o_rd_resp[p].data   = i_array_s1_data;
  end

  // The array reports a hit only behind a granted read
  a_hit_needs_grant : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    !(|r_grant) |-> !i_array_s1_hit
  );

endmodule

// ==== hdl/lsu_l1d_pkg.sv ====
package lsu_l1d_pkg;

  // ----------------------------------------------------------------------
  // Widths
  // ----------------------------------------------------------------------
  localparam int PADDR_W         = 32;
  localparam int DCACHE_DATA_W   = 128;
  localparam int DCACHE_DATA_B_W = DCACHE_DATA_W / 8;
  localparam int XLEN_W          = 64;

  // ----------------------------------------------------------------------
  // Encodings
  // ----------------------------------------------------------------------
  typedef enum logic [1:0] {
    STATUS_NONE         = 2'd0,
    STATUS_HIT          = 2'd1,
    STATUS_MISS         = 2'd2,
    STATUS_L1D_CONFLICT = 2'd3
  } l1d_status_t;

  typedef enum logic {
    SNOOP_READ    = 1'b0,
    SNOOP_INVALID = 1'b1
  } snoop_cmd_t;

  // ----------------------------------------------------------------------
  // Request and response bundles
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic               valid;
    logic [PADDR_W-1:0] paddr;
  } l1d_rd_req_t;

  typedef struct packed {
    logic                     valid;
    l1d_status_t              status;
    logic [DCACHE_DATA_W-1:0] data;
  } l1d_rd_resp_t;

  // Invalidate clears the valid bit, otherwise a line fill
  typedef struct packed {
    logic                     valid;
    logic                     invalidate;
    logic [PADDR_W-1:0]       paddr;
    logic [DCACHE_DATA_W-1:0] data;
  } l1d_wr_req_t;

  typedef struct packed {
    logic               valid;
    snoop_cmd_t         cmd;
    logic [PADDR_W-1:0] paddr;
  } snoop_req_t;

  typedef struct packed {
    logic                       valid;
    l1d_status_t                status;
    logic [DCACHE_DATA_B_W-1:0] be;
    logic [DCACHE_DATA_W-1:0]   data;
  } snoop_resp_t;

  typedef struct packed {
    logic               valid;
    logic [PADDR_W-1:0] paddr;
  } ptw_req_t;

  typedef struct packed {
    logic        valid;
    l1d_status_t status;
    logic [XLEN_W-1:0] data;
  } ptw_resp_t;

endpackage
